//--- logic/MicrorocPkg.sv
package MicrorocPkg;

  ////////////////////////////////////////
  // Host register map
  ////////////////////////////////////////

  // Slow-control slices sit at 0..7, word 0 holds the LSBs
  typedef enum logic [3:0] {
    AddrScWord0 = 4'd0,  // First slow-control slice
    AddrCtrl    = 4'd8,  // Control bits
    AddrAcqTime = 4'd9   // START_ACQ length in Clk cycles
  } CfgAddrT;

  // Control register bit positions
  localparam int CtrlScSelectBit   = 0;  // SELECT pin level
  localparam int CtrlChainBit      = 1;  // 0 chain 1, 1 chain 2
  localparam int CtrlPowerPulseBit = 2;  // PWR_ON pins follow sequencer

  ////////////////////////////////////////
  // Acquisition sequencer
  ////////////////////////////////////////

  typedef enum logic [2:0] {
    Idle,       // Waiting for AcqStart
    PowerUp,    // Analog and digital supplies settling
    Acquire,    // START_ACQ high
    StartRo,    // One cycle readout kick
    WaitEnd,    // ASIC shifting its RAM out
    PowerDown   // OnceEnd back to host
  } AcqStateT;

  // Supply settle time before START_ACQ
  localparam int PowerSettleCycles = 4;

endpackage

//--- logic/MicrorocRegs.sv
`timescale 1ns/1ps

module MicrorocRegs #(
  parameter int ScBits = 64  // Multiple of 16, up to 128
) (
  input  logic                 Clk,
  input  logic                 rstN,
  input  logic                 CfgWrite,    // One-cycle write strobe
  input  MicrorocPkg::CfgAddrT CfgAddr,
  input  logic [15:0]          CfgData,
  output logic [ScBits-1:0]    ScWord,      // To slow-control loader
  output logic                 ScSelect,    // Straight to SELECT pin
  output logic                 ChainSelect, // Redundancy choice
  output logic                 PowerPulseEnable,
  output logic [15:0]          AcqTime
);
  import MicrorocPkg::*;

  localparam int ScWords = ScBits / 16;  // Number of 16-bit slices

  ////////////////////////////////////////
  // Slow-control word slices
  ////////////////////////////////////////

  // Slice addresses past ScWords fall through untouched
  always_ff @(posedge Clk) begin
    if (CfgWrite) begin
      for (int i = 0; i < ScWords; i++) begin
        if (int'(CfgAddr) == int'(AddrScWord0) + i) begin
          ScWord[i*16 +: 16] <= CfgData;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Control and acquisition time
  ////////////////////////////////////////

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      ScSelect         <= 1'b0;
      ChainSelect      <= 1'b0;   // Chain 1
      PowerPulseEnable <= 1'b0;   // Supplies always on
      AcqTime          <= 16'd1;
    end else if (CfgWrite) begin
      case (CfgAddr)
        AddrCtrl: begin
          ScSelect         <= CfgData[CtrlScSelectBit];
          ChainSelect      <= CfgData[CtrlChainBit];
          PowerPulseEnable <= CfgData[CtrlPowerPulseBit];
        end
        AddrAcqTime: AcqTime <= CfgData;
        default: ;                // Slices handled above
      endcase
    end
  end

  // Zero would wrap the sequencer's Acquire count to 65536 cycles
  acqTimeNonZero: assert property (@(posedge Clk) disable iff (!rstN)
    (CfgWrite && CfgAddr == AddrAcqTime) |-> (CfgData != 16'd0))
    else $error("AcqTime written as zero");

endmodule

//--- logic/SlowControlLoader.sv
`timescale 1ns/1ps

module SlowControlLoader #(
  parameter int ScBits   = 64,
  parameter int SrClkDiv = 2   // Clk cycles per SR_CK half period
) (
  input  logic              Clk,
  input  logic              rstN,
  input  logic              ParameterLoadStart,
  input  logic [ScBits-1:0] ScWord,
  output logic              ParameterLoadDone,
  output logic              SR_RSTB,   // Selected register reset, active low
  output logic              SR_CK,
  output logic              SR_IN
);

  localparam int DivW = $clog2(SrClkDiv + 1);
  localparam int BitW = $clog2(ScBits);
  localparam logic [DivW-1:0] DivLast = DivW'(SrClkDiv - 1);
  localparam logic [BitW-1:0] BitLast = BitW'(ScBits - 1);

  typedef enum logic [1:0] {
    LdIdle,
    LdReset,  // SR_RSTB low, two cycles
    LdShift   // SR_CK running
  } LoadStateT;

  LoadStateT         state;
  logic [DivW-1:0]   divCnt;   // Half-period divider, also reset timer
  logic [BitW-1:0]   bitCnt;   // Bits already clocked out
  logic [ScBits-1:0] shiftReg; // Private copy of ScWord
  logic              startLoad;
  logic              loadBit;  // Next MSB goes onto SR_IN

  assign startLoad = (state == LdIdle) && ParameterLoadStart;
  assign loadBit   = ((state == LdReset) && (divCnt == DivW'(1)))
                  || ((state == LdShift) && (divCnt == DivLast) && SR_CK
                      && (bitCnt != BitLast));  // On SR_CK fall

  // Word copy, MSB first
  always_ff @(posedge Clk) begin
    if (startLoad) shiftReg <= ScWord;
    else if (loadBit) shiftReg <= shiftReg << 1;
  end

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      state             <= LdIdle;
      divCnt            <= '0;
      bitCnt            <= '0;
      ParameterLoadDone <= 1'b0;
      SR_RSTB           <= 1'b1;
      SR_CK             <= 1'b0;
      SR_IN             <= 1'b0;
    end else begin
      ParameterLoadDone <= 1'b0;
      if (loadBit) SR_IN <= shiftReg[ScBits-1];  // Changes with SR_CK low
      case (state)
        LdIdle: begin
          divCnt <= '0;
          if (startLoad) begin
            state   <= LdReset;
            SR_RSTB <= 1'b0;
          end
        end
        LdReset: begin
          divCnt <= divCnt + 1'b1;
          if (divCnt == DivW'(1)) begin
            state   <= LdShift;
            SR_RSTB <= 1'b1;
            divCnt  <= '0;
            bitCnt  <= '0;
          end
        end
        LdShift: begin
          divCnt <= divCnt + 1'b1;
          if (divCnt == DivLast) begin
            divCnt <= '0;
            SR_CK  <= ~SR_CK;
            if (SR_CK && bitCnt == BitLast) begin  // Last fall
              state             <= LdIdle;
              SR_IN             <= 1'b0;
              ParameterLoadDone <= 1'b1;
            end else if (SR_CK) begin
              bitCnt <= bitCnt + 1'b1;
            end
          end
        end
        default: state <= LdIdle;
      endcase
    end
  end

  // No stray shift clocks into the ASIC outside a load
  srCkQuiet: assert property (@(posedge Clk) disable iff (!rstN)
    (state != LdShift) |-> !SR_CK)
    else $error("SR_CK high outside a load");

endmodule

//--- logic/AcqSequencer.sv
`timescale 1ns/1ps

module AcqSequencer (
  input  logic        Clk,
  input  logic        rstN,
  input  logic        AcqStart,          // One-cycle host pulse
  input  logic        PowerPulseEnable,
  input  logic [15:0] AcqTime,
  input  logic        CHIPSATB,          // Chip full, active low
  input  logic        EndReadout,        // From selected chain
  output logic        START_ACQ,
  output logic        StartReadout,      // One-cycle pulse
  output logic        OnceEnd,           // One-cycle pulse to host
  output logic        PWR_ON_A,
  output logic        PWR_ON_D,
  output logic        PWR_ON_ADC,
  output logic        PWR_ON_DAC
);
  import MicrorocPkg::*;

  AcqStateT    state;
  AcqStateT    nextState;
  logic [15:0] cycleCnt;   // Cycles spent in current state
  logic        powerOn;    // Sequencer wants supplies up
  logic        powerPins;

  ////////////////////////////////////////
  // Next state
  ////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      Idle:      if (AcqStart) nextState = PowerUp;  // Ignored elsewhere
      PowerUp: begin
        if (cycleCnt == 16'(PowerSettleCycles - 1)) nextState = Acquire;
      end
      Acquire: begin
        // Early stop once chip reports full
        if (!CHIPSATB || cycleCnt == AcqTime - 16'd1) nextState = StartRo;
      end
      StartRo:   nextState = WaitEnd;
      WaitEnd:   if (EndReadout) nextState = PowerDown;
      PowerDown: nextState = Idle;
      default:   nextState = Idle;
    endcase
  end

  ////////////////////////////////////////
  // State, counter and registered pins
  ////////////////////////////////////////

  // Outputs decoded from nextState so they line up with state
  always_ff @(posedge Clk) begin
    if (!rstN) begin
      state        <= Idle;
      cycleCnt     <= '0;
      START_ACQ    <= 1'b0;
      StartReadout <= 1'b0;
      OnceEnd      <= 1'b0;
      powerOn      <= 1'b0;
    end else begin
      state        <= nextState;
      // Restart count on every transition
      cycleCnt     <= (nextState != state) ? 16'd0 : cycleCnt + 16'd1;
      START_ACQ    <= (nextState == Acquire);
      StartReadout <= (nextState == StartRo);
      OnceEnd      <= (nextState == PowerDown);
      powerOn      <= (nextState != Idle);
    end
  end

  // Supplies on constantly unless power pulsing
  assign powerPins  = powerOn | ~PowerPulseEnable;
  assign PWR_ON_A   = powerPins;
  assign PWR_ON_D   = powerPins;
  assign PWR_ON_ADC = powerPins;
  assign PWR_ON_DAC = powerPins;

  // Acquisition must be closed before readout kicks off
  acqReadoutExclusive: assert property (@(posedge Clk) disable iff (!rstN)
    !(START_ACQ && StartReadout))
    else $error("START_ACQ overlaps StartReadout");

  acqOnlyInAcquire: assert property (@(posedge Clk) disable iff (!rstN)
    START_ACQ |-> (state == Acquire))
    else $error("START_ACQ high outside Acquire");

endmodule

//--- logic/RamReadout.sv
`timescale 1ns/1ps

module RamReadout (
  input  logic        Clk,
  input  logic        rstN,
  input  logic        ChainSelect,     // 0 chain 1, 1 chain 2
  input  logic        StartReadout,    // Pulse from sequencer
  input  logic        END_READOUT1,
  input  logic        END_READOUT2,
  input  logic        DOUT1B,          // Inverted serial data
  input  logic        DOUT2B,
  input  logic        TRANSMITON1B,    // Low while chain shifts data
  input  logic        TRANSMITON2B,
  output logic        START_READOUT1,
  output logic        START_READOUT2,
  output logic        EndReadout,
  output logic [15:0] RamData,
  output logic        RamDataValid     // One-cycle strobe, no back-pressure
);

  logic        doutB;        // Selected chain data
  logic        transmitOnB;  // Selected chain gate
  logic [15:0] shiftReg;
  logic [3:0]  bitCnt;       // Bits in current word

  ////////////////////////////////////////
  // Chain redundancy
  ////////////////////////////////////////

  // Start only reaches the chosen chain
  assign START_READOUT1 = StartReadout & ~ChainSelect;
  assign START_READOUT2 = StartReadout &  ChainSelect;

  assign EndReadout  = ChainSelect ? END_READOUT2 : END_READOUT1;
  assign doutB       = ChainSelect ? DOUT2B       : DOUT1B;
  assign transmitOnB = ChainSelect ? TRANSMITON2B : TRANSMITON1B;

  ////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////

  // First sample ends up in bit 15
  always_ff @(posedge Clk) begin
    if (!transmitOnB) shiftReg <= {shiftReg[14:0], ~doutB};
  end

  always_ff @(posedge Clk) begin
    if (!rstN) begin
      bitCnt       <= '0;
      RamDataValid <= 1'b0;
    end else begin
      RamDataValid <= 1'b0;
      if (!transmitOnB) begin
        bitCnt <= bitCnt + 4'd1;                 // Wraps to 0 per word
        if (bitCnt == 4'd15) RamDataValid <= 1'b1;
      end else begin
        bitCnt <= '0;                            // Drop partial word
      end
    end
  end

  // Word stays put only in the valid cycle
  assign RamData = shiftReg;

  // Idle chain must never see a start edge
  unselectedStartQuiet: assert property (@(posedge Clk) disable iff (!rstN)
    !($rose(START_READOUT1) && ChainSelect)
    && !($rose(START_READOUT2) && !ChainSelect))
    else $error("START_READOUT on unselected chain");

endmodule

//--- logic/MicrorocControl.sv
`timescale 1ns/1ps

module MicrorocControl #(
  parameter int ScBits   = 64,
  parameter int SrClkDiv = 2
) (
  input  logic                 Clk,
  input  logic                 rstN,
  // Host side
  input  logic                 CfgWrite,
  input  MicrorocPkg::CfgAddrT CfgAddr,
  input  logic [15:0]          CfgData,
  input  logic                 ParameterLoadStart,
  output logic                 ParameterLoadDone,
  input  logic                 AcqStart,
  output logic                 OnceEnd,
  output logic [15:0]          RamData,
  output logic                 RamDataValid,
  // Slow control pins
  output logic                 SELECT,       // 1 slow control, 0 read register
  output logic                 SR_RSTB,
  output logic                 SR_CK,
  output logic                 SR_IN,
  // Power pulsing pins
  output logic                 PWR_ON_A,
  output logic                 PWR_ON_D,
  output logic                 PWR_ON_ADC,
  output logic                 PWR_ON_DAC,
  // Acquisition and readout pins
  output logic                 START_ACQ,
  input  logic                 CHIPSATB,
  output logic                 START_READOUT1,
  output logic                 START_READOUT2,
  input  logic                 END_READOUT1,
  input  logic                 END_READOUT2,
  input  logic                 DOUT1B,
  input  logic                 DOUT2B,
  input  logic                 TRANSMITON1B,
  input  logic                 TRANSMITON2B
);

  logic [ScBits-1:0] scWord;
  logic              chainSelect;
  logic              powerPulseEnable;
  logic [15:0]       acqTime;
  logic              startReadout;
  logic              endReadout;

  MicrorocRegs #(.ScBits(ScBits)) regs (
    .Clk(Clk), .rstN(rstN),
    .CfgWrite(CfgWrite), .CfgAddr(CfgAddr), .CfgData(CfgData),
    .ScWord(scWord), .ScSelect(SELECT), .ChainSelect(chainSelect),
    .PowerPulseEnable(powerPulseEnable), .AcqTime(acqTime)
  );

  SlowControlLoader #(.ScBits(ScBits), .SrClkDiv(SrClkDiv)) scLoader (
    .Clk(Clk), .rstN(rstN),
    .ParameterLoadStart(ParameterLoadStart), .ScWord(scWord),
    .ParameterLoadDone(ParameterLoadDone),
    .SR_RSTB(SR_RSTB), .SR_CK(SR_CK), .SR_IN(SR_IN)
  );

  AcqSequencer acqSeq (
    .Clk(Clk), .rstN(rstN),
    .AcqStart(AcqStart), .PowerPulseEnable(powerPulseEnable), .AcqTime(acqTime),
    .CHIPSATB(CHIPSATB), .EndReadout(endReadout),
    .START_ACQ(START_ACQ), .StartReadout(startReadout), .OnceEnd(OnceEnd),
    .PWR_ON_A(PWR_ON_A), .PWR_ON_D(PWR_ON_D),
    .PWR_ON_ADC(PWR_ON_ADC), .PWR_ON_DAC(PWR_ON_DAC)
  );

  RamReadout ramRo (
    .Clk(Clk), .rstN(rstN),
    .ChainSelect(chainSelect), .StartReadout(startReadout),
    .END_READOUT1(END_READOUT1), .END_READOUT2(END_READOUT2),
    .DOUT1B(DOUT1B), .DOUT2B(DOUT2B),
    .TRANSMITON1B(TRANSMITON1B), .TRANSMITON2B(TRANSMITON2B),
    .START_READOUT1(START_READOUT1), .START_READOUT2(START_READOUT2),
    .EndReadout(endReadout), .RamData(RamData), .RamDataValid(RamDataValid)
  );

endmodule

//--- sim/tbMicrorocControl.sv
`timescale 1ns/1ps

module tbMicrorocControl;
  import MicrorocPkg::*;

  localparam int ScBits      = 64;
  localparam int SrClkDiv    = 2;
  localparam int LoadTimeout = 2 + 2 * SrClkDiv * ScBits + 40;  // Reset, shift, slack
  localparam int AcqTimeout  = 400;

  logic        Clk;
  logic        rstN;
  logic        CfgWrite;
  CfgAddrT     CfgAddr;
  logic [15:0] CfgData;
  logic        ParameterLoadStart;
  logic        ParameterLoadDone;
  logic        AcqStart;
  logic        OnceEnd;
  logic [15:0] RamData;
  logic        RamDataValid;
  logic        SELECT, SR_RSTB, SR_CK, SR_IN;
  logic        PWR_ON_A, PWR_ON_D, PWR_ON_ADC, PWR_ON_DAC;
  logic        START_ACQ, CHIPSATB;
  logic        START_READOUT1, START_READOUT2, END_READOUT1, END_READOUT2;
  logic        DOUT1B, DOUT2B, TRANSMITON1B, TRANSMITON2B;

  integer      seed = 32'h2db1_6777;
  int          errors = 0;
  int          timeouts = 0;

  // ASIC model state
  logic        chainSel = 1'b0;     // Chain the model answers on
  int          roLeft = 0;          // Data cycles left in window
  logic        endPending = 1'b0;
  logic        endNow = 1'b0;       // END_READOUT driven this cycle
  int          lastK = 0;           // Words in last window
  logic [15:0] shiftWord;
  logic [15:0] expWords[$];

  MicrorocControl #(.ScBits(ScBits), .SrClkDiv(SrClkDiv)) i_dut (.*);

  initial Clk = 1'b0;
  always #20 Clk = ~Clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic logMismatch(input string msg);
    errors++;
    $display("[ERROR] %0t ns: %s", $time, msg);
  endtask

  task automatic reportTimeout(input string what);
    timeouts++;
    $display("Timed out waiting for %s at %0t ns", what, $time);
  endtask

  // ASIC side driven once per falling edge
  task automatic driveAsic();
    logic [31:0] noise;
    logic        selStart;
    logic        selTx;
    logic        selDout;
    noise    = $random(seed);
    selStart = chainSel ? START_READOUT2 : START_READOUT1;
    selTx    = 1'b1;
    selDout  = noise[3];
    endNow   = 1'b0;
    if (roLeft == 0 && !endPending && selStart === 1'b1) begin
      lastK  = 1 + ({$random(seed)} % 3);
      roLeft = 16 * lastK;              // TRANSMITON low for k words
    end
    if (roLeft > 0) begin
      selTx     = 1'b0;
      selDout   = noise[4];
      shiftWord = {shiftWord[14:0], ~noise[4]};  // Pin is inverted data
      roLeft--;
      if (roLeft % 16 == 0) expWords.push_back(shiftWord);
      if (roLeft == 0) endPending = 1'b1;
    end else if (endPending) begin
      endNow     = 1'b1;                // One-cycle END_READOUT
      endPending = 1'b0;
    end
    if (chainSel) begin
      DOUT1B       = noise[0];          // Garbage on idle chain
      TRANSMITON1B = noise[1];
      END_READOUT1 = noise[2];
      DOUT2B       = selDout;
      TRANSMITON2B = selTx;
      END_READOUT2 = endNow;
    end else begin
      DOUT2B       = noise[0];
      TRANSMITON2B = noise[1];
      END_READOUT2 = noise[2];
      DOUT1B       = selDout;
      TRANSMITON1B = selTx;
      END_READOUT1 = endNow;
    end
  endtask

  task automatic tick();
    @(negedge Clk);
    driveAsic();
  endtask

  task automatic writeReg(input CfgAddrT addr, input logic [15:0] data);
    CfgWrite = 1'b1;
    CfgAddr  = addr;
    CfgData  = data;
    tick();
    CfgWrite = 1'b0;                    // Value visible from here
  endtask

  function automatic logic [15:0] ctrlWord(input logic sel, input logic chain, input logic pp);
    logic [15:0] w;
    w                    = '0;
    w[CtrlScSelectBit]   = sel;
    w[CtrlChainBit]      = chain;
    w[CtrlPowerPulseBit] = pp;
    return w;
  endfunction

  ////////////////////////////////////////
  // Slow-control load
  ////////////////////////////////////////

  task automatic loadSlowControl();
    logic [ScBits-1:0] expWord;
    logic [ScBits-1:0] captured;
    logic [15:0]       slice;
    logic              selBit;
    logic              prevCk;
    int                edges;
    int                rstbLow;   // Cycles with SR_RSTB low
    int                cyc;
    bit                doneSeen;
    for (int s = 0; s < ScBits / 16; s++) begin
      slice                 = $random(seed);
      expWord[s*16 +: 16]   = slice;   // Slice 0 holds the LSBs
      writeReg(CfgAddrT'(s), slice);
    end
    selBit = $random(seed);
    writeReg(AddrCtrl, ctrlWord(selBit, 1'b0, 1'b0));
    assert (SELECT == selBit)
      else logMismatch($sformatf("SELECT %b, expected %b", SELECT, selBit));
    ParameterLoadStart = 1'b1;
    captured = '0;
    prevCk   = 1'b0;
    edges    = 0;
    rstbLow  = 0;
    cyc      = 0;
    doneSeen = 1'b0;
    while (!doneSeen && cyc < LoadTimeout) begin
      tick();
      cyc++;
      ParameterLoadStart = (cyc == 20);  // Stray start mid-load
      if (!SR_RSTB) rstbLow++;
      if (SR_CK && !prevCk) begin
        captured = {captured[ScBits-2:0], SR_IN};  // MSB arrives first
        edges++;
      end
      prevCk   = SR_CK;
      doneSeen = ParameterLoadDone;
    end
    ParameterLoadStart = 1'b0;
    if (!doneSeen) reportTimeout("ParameterLoadDone");
    assert (rstbLow == 2)
      else logMismatch($sformatf("SR_RSTB low %0d cycles, expected 2", rstbLow));
    assert (edges == ScBits)
      else logMismatch($sformatf("%0d SR_CK rising edges, expected %0d", edges, ScBits));
    assert (captured == expWord)
      else logMismatch($sformatf("SR_IN word %h, expected %h", captured, expWord));
  endtask

  ////////////////////////////////////////
  // Acquisition and readout
  ////////////////////////////////////////

  task automatic runAcq(input logic chain, input logic pp);
    logic [15:0] acqT;
    int          dropAt;     // START_ACQ cycle that sees chip full, 0 never
    int          expHigh;
    int          riseAt;
    int          highCnt;
    int          roPulses;
    int          words;
    int          cyc;
    logic        prevEnd;
    bit          doneSeen;
    acqT = 16'(1 + {$random(seed)} % 24);
    if ({$random(seed)} % 2) dropAt = 1 + {$random(seed)} % (acqT + 3);
    else dropAt = 0;
    expHigh  = (dropAt != 0 && dropAt < acqT) ? dropAt : acqT;
    chainSel = chain;
    writeReg(AddrCtrl, ctrlWord(1'b0, chain, pp));
    writeReg(AddrAcqTime, acqT);
    assert ({PWR_ON_A, PWR_ON_D, PWR_ON_ADC, PWR_ON_DAC} == {4{!pp}})
      else logMismatch($sformatf("Idle PWR_ON wrong with pulsing %b", pp));
    AcqStart = 1'b1;
    lastK    = 0;
    riseAt   = -1;
    highCnt  = 0;
    roPulses = 0;
    words    = 0;
    cyc      = 0;
    prevEnd  = 1'b0;
    doneSeen = 1'b0;
    while (!doneSeen && cyc < AcqTimeout) begin
      tick();
      cyc++;                             // Edges since AcqStart was sampled
      AcqStart = 1'b0;
      assert (PWR_ON_A && PWR_ON_D && PWR_ON_ADC && PWR_ON_DAC)
        else logMismatch("PWR_ON low during acquisition");
      if (START_ACQ) begin
        if (riseAt < 0) riseAt = cyc - 1;
        highCnt++;
        if (highCnt == dropAt) CHIPSATB = 1'b0;  // Chip full
      end
      assert (!(chain ? START_READOUT1 : START_READOUT2))
        else logMismatch("START_READOUT on unselected chain");
      if (chain ? START_READOUT2 : START_READOUT1) roPulses++;
      if (RamDataValid) begin
        words++;
        assert (expWords.size() != 0)
          else logMismatch("RamDataValid with no word expected");
        if (expWords.size() != 0) begin
          assert (RamData == expWords[0])
            else logMismatch($sformatf("RamData %h, expected %h", RamData, expWords[0]));
          void'(expWords.pop_front());
        end
      end
      if (OnceEnd) begin
        doneSeen = 1'b1;
        assert (prevEnd)
          else logMismatch("OnceEnd without END_READOUT one cycle before");
      end
      prevEnd = endNow;
    end
    CHIPSATB = 1'b1;
    if (!doneSeen) reportTimeout("OnceEnd");
    assert (riseAt == PowerSettleCycles)
      else logMismatch($sformatf("START_ACQ rose after %0d cycles", riseAt));
    assert (highCnt == expHigh)
      else logMismatch($sformatf("START_ACQ high %0d cycles, expected %0d", highCnt, expHigh));
    assert (roPulses == 1)
      else logMismatch($sformatf("%0d START_READOUT pulses, expected 1", roPulses));
    assert (words == lastK && expWords.size() == 0)
      else logMismatch($sformatf("%0d RamData words, expected %0d", words, lastK));
    expWords.delete();
    tick();
    assert ({PWR_ON_A, PWR_ON_D, PWR_ON_ADC, PWR_ON_DAC} == {4{!pp}})
      else logMismatch("PWR_ON wrong after OnceEnd");
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rstN               = 1'b0;
    CfgWrite           = 1'b0;
    CfgAddr            = AddrScWord0;
    CfgData            = '0;
    ParameterLoadStart = 1'b0;
    AcqStart           = 1'b0;
    CHIPSATB           = 1'b1;
    END_READOUT1       = 1'b0;
    END_READOUT2       = 1'b0;
    DOUT1B             = 1'b1;
    DOUT2B             = 1'b1;
    TRANSMITON1B       = 1'b1;
    TRANSMITON2B       = 1'b1;
    repeat (10) tick();
    rstN = 1'b1;
    tick();
    assert (!SR_CK && !START_ACQ && !START_READOUT1 && !START_READOUT2 && !RamDataValid)
      else logMismatch("Strobe output active after reset");
    assert (!SELECT && SR_RSTB && !ParameterLoadDone && !OnceEnd)
      else logMismatch("Slow-control pins wrong after reset");
    assert ({PWR_ON_A, PWR_ON_D, PWR_ON_ADC, PWR_ON_DAC} == 4'hf)
      else logMismatch("PWR_ON low after reset");
    repeat (3) loadSlowControl();
    for (int i = 0; i < 8; i++) runAcq(i[0], i[1]);  // Both chains, pulsing on and off
    $display("Closing counts: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
logic/MicrorocPkg.sv
logic/MicrorocRegs.sv
logic/SlowControlLoader.sv
logic/AcqSequencer.sv
logic/RamReadout.sv
logic/MicrorocControl.sv
sim/tbMicrorocControl.sv
